// File: design/isa_pkg.sv
// Instruction set constants shared by the fetch front end
package isa_pkg;

  //////////////////////////////////////////////////////////////////////
  // Word and address widths
  //////////////////////////////////////////////////////////////////////
  localparam int WORD_W = 16;  // Instruction and data word
  localparam int ADDR_W = 16;  // Byte address

  //////////////////////////////////////////////////////////////////////
  // Instruction ROM
  //////////////////////////////////////////////////////////////////////
  localparam int IMEM_WORDS = 32;                   // Depth in 16-bit words
  localparam int IMEM_AW    = $clog2(IMEM_WORDS);   // Word index width
  localparam int IMEM_LSB   = 1;                    // Bit 0 is the byte offset

  // ROM image opened from the run directory
  localparam string IMEM_FILE = "imem.hex";

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////
  // Bubble inserted by a flush
  localparam logic [WORD_W-1:0] NOP_INSTR = '0;

  // Opcode field sits in bits 15 to 12
  localparam int OPC_LSB = 12;
  localparam int OPC_W   = 4;

  localparam logic [OPC_W-1:0] OP_BRANCH = 4'b1100;  // Conditional branch

endpackage

// File: design/bpred_pkg.sv
// Sizes and encodings of the dynamic branch predictor
package bpred_pkg;

  //////////////////////////////////////////////////////////////////////
  // Table sizes
  //////////////////////////////////////////////////////////////////////
  localparam int BHT_ENTRIES = 8;  // 2-bit saturating counters
  localparam int BTB_ENTRIES = 8;  // Tagged target entries

  //////////////////////////////////////////////////////////////////////
  // PC slicing
  //////////////////////////////////////////////////////////////////////
  // Both tables are indexed by PC bits 3 to 1
  localparam int IDX_LSB = 1;
  localparam int IDX_W   = 3;

  // Tag holds every PC bit above the index
  localparam int TAG_LSB = IDX_LSB + IDX_W;
  localparam int TAG_W   = 12;

  //////////////////////////////////////////////////////////////////////
  // Counter states
  //////////////////////////////////////////////////////////////////////
  localparam logic [1:0] CTR_SNT = 2'd0;  // Strongly not taken
  localparam logic [1:0] CTR_WNT = 2'd1;  // Weakly not taken
  localparam logic [1:0] CTR_WT  = 2'd2;  // Weakly taken
  localparam logic [1:0] CTR_ST  = 2'd3;  // Strongly taken

  localparam logic [1:0] CTR_RESET = CTR_WNT;

endpackage

// File: design/branch_predictor.sv
`timescale 1ns/1ns

// Branch history table plus tagged branch target buffer
// Lookup is combinational on pc_curr and update is clocked from the ID stage
module branch_predictor import isa_pkg::*, bpred_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              enable,            // Low while the pipeline stalls
  input  logic [ADDR_W-1:0] pc_curr,           // Address being fetched
  input  logic [ADDR_W-1:0] id_pc,             // Address of the branch in decode
  input  logic [1:0]        id_prediction,     // Counter value seen at its fetch
  input  logic              wen_bht,           // Counter update strobe
  input  logic              wen_btb,           // Target write strobe
  input  logic              actual_taken,      // Resolved direction
  input  logic [ADDR_W-1:0] actual_target,     // Resolved target to cache
  output logic              predicted_taken,   // Redirect fetch to the BTB target
  output logic [1:0]        prediction,        // Raw counter for the fetched PC
  output logic [ADDR_W-1:0] predicted_target   // Cached target for the fetched PC
);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////
  logic [1:0]        bht        [BHT_ENTRIES];  // Direction counters
  logic [TAG_W-1:0]  btb_tag    [BTB_ENTRIES];  // Upper PC bits of the owner
  logic [ADDR_W-1:0] btb_target [BTB_ENTRIES];  // Taken target
  logic [BTB_ENTRIES-1:0] btb_valid;            // Entry written since reset

  // Read side slices
  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic             btb_hit;

  // Write side slices
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;
  logic [1:0]       ctr_next;  // Counter after one saturating step

  assign rd_idx = pc_curr[IDX_LSB +: IDX_W];
  assign rd_tag = pc_curr[TAG_LSB +: TAG_W];
  assign wr_idx = id_pc[IDX_LSB +: IDX_W];
  assign wr_tag = id_pc[TAG_LSB +: TAG_W];

  //////////////////////////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////////////////////////
  assign btb_hit = btb_valid[rd_idx] && (btb_tag[rd_idx] == rd_tag);

  assign prediction       = bht[rd_idx];
  assign predicted_target = btb_target[rd_idx];

  // Only redirect when the counter says taken and the target is known
  assign predicted_taken = prediction[1] & btb_hit;

  //////////////////////////////////////////////////////////////////////
  // Update
  //////////////////////////////////////////////////////////////////////
  // Step from the value the branch was predicted with
  always_comb begin
    ctr_next = id_prediction;
    if (actual_taken) begin
      if (id_prediction != CTR_ST)
        ctr_next = id_prediction + 2'd1;  // Move toward taken
    end else begin
      if (id_prediction != CTR_SNT)
        ctr_next = id_prediction - 2'd1;  // Move toward not taken
    end
  end

  // Counters and valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < BHT_ENTRIES; i++)
        bht[i] <= CTR_RESET;  // Start weakly not taken
      btb_valid <= '0;
    end else if (enable) begin
      if (wen_bht)
        bht[wr_idx] <= ctr_next;
      if (wen_btb)
        btb_valid[wr_idx] <= 1'b1;
    end
  end

  // Tag and target payload
  always_ff @(posedge clk) begin
    if (enable && wen_btb) begin
      btb_tag[wr_idx]    <= wr_tag;
      btb_target[wr_idx] <= actual_target;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////
  // id_pc comes back from the IF/ID register and must be known by now
  a_bht_idx_known : assert property (
    @(posedge clk) disable iff (rst)
    wen_bht |-> !$isunknown(wr_idx)
  ) else $error("BHT write with unknown index, id_pc=%h", id_pc);

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/1ns

// Fetch stage with PC register, next-PC select, predictor and instruction ROM
module fetch_stage import isa_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              stall,              // Hold the PC
  input  logic              update_pc,          // Misprediction redirect
  input  logic [ADDR_W-1:0] actual_target,      // Corrected next address
  input  logic              actual_taken,       // Resolved branch direction
  input  logic              wen_bht,
  input  logic              wen_btb,
  input  logic [ADDR_W-1:0] branch_target,      // Target written into the BTB
  input  logic [ADDR_W-1:0] id_pc,              // PC of the instruction in decode
  input  logic [1:0]        id_prediction,      // Its counter value at fetch
  output logic [ADDR_W-1:0] pc_curr,
  output logic [WORD_W-1:0] pc_inst,            // ROM word at pc_curr
  output logic [1:0]        prediction,
  output logic [ADDR_W-1:0] predicted_target
);

  logic              enable;           // High when not stalled
  logic              predicted_taken;
  logic [ADDR_W-1:0] pc_plus2;
  logic [ADDR_W-1:0] pc_new;

  // ROM contents come from the hex image
  logic [WORD_W-1:0] imem [IMEM_WORDS];

  assign enable = ~stall;

  //////////////////////////////////////////////////////////////////////
  // Next-PC selection
  //////////////////////////////////////////////////////////////////////
  assign pc_plus2 = pc_curr + ADDR_W'(2);  // Sequential fetch

  // Redirect first, then predicted taken, then fall through
  assign pc_new = update_pc       ? actual_target    :
                  predicted_taken ? predicted_target :
                                    pc_plus2;

  // A redirect overrides a stall
  always_ff @(posedge clk) begin
    if (rst)
      pc_curr <= '0;
    else if (enable || update_pc)
      pc_curr <= pc_new;
  end

  branch_predictor branch_predictor_i (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .pc_curr          (pc_curr),
    .id_pc            (id_pc),
    .id_prediction    (id_prediction),
    .wen_bht          (wen_bht),
    .wen_btb          (wen_btb),
    .actual_taken     (actual_taken),
    .actual_target    (branch_target),  // BTB caches the decoded target
    .predicted_taken  (predicted_taken),
    .prediction       (prediction),
    .predicted_target (predicted_target)
  );

  //////////////////////////////////////////////////////////////////////
  // Instruction ROM
  //////////////////////////////////////////////////////////////////////
  initial $readmemh(IMEM_FILE, imem);

  // Word index wraps over the ROM depth
  assign pc_inst = imem[pc_curr[IMEM_LSB +: IMEM_AW]];

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////
  // Targets from the BTB and from decode must keep 2-byte alignment
  a_pc_even : assert property (
    @(posedge clk) disable iff (rst) pc_curr[0] == 1'b0
  ) else $error("Odd PC %h", pc_curr);

  a_pc_hold : assert property (
    @(posedge clk) disable iff (rst)
    stall && !update_pc |=> $stable(pc_curr)
  ) else $error("PC moved under stall");

endmodule

// File: design/if_id_reg.sv
`timescale 1ns/1ns

// IF/ID pipeline register with stall hold and flush to a bubble
module if_id_reg import isa_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              stall,              // Hold contents
  input  logic              update_pc,          // Flush on redirect
  input  logic [ADDR_W-1:0] pc_curr,
  input  logic [WORD_W-1:0] pc_inst,
  input  logic [1:0]        prediction,
  input  logic [ADDR_W-1:0] predicted_target,
  output logic              id_valid,
  output logic [ADDR_W-1:0] id_pc,
  output logic [WORD_W-1:0] id_instr,
  output logic [1:0]        id_prediction,
  output logic [ADDR_W-1:0] id_predicted_target
);

  logic capture;  // Normal load from fetch

  assign capture = ~stall & ~update_pc;

  // Valid bit and instruction form the bubble
  always_ff @(posedge clk) begin
    if (rst || update_pc) begin
      id_valid <= 1'b0;
      id_instr <= NOP_INSTR;
    end else if (capture) begin
      id_valid <= 1'b1;
      id_instr <= pc_inst;
    end
  end

  // Side information follows the instruction and holds on a flush
  always_ff @(posedge clk) begin
    if (capture) begin
      id_pc               <= pc_curr;
      id_prediction       <= prediction;
      id_predicted_target <= predicted_target;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////
  // Decode must never see a live opcode in a bubble
  a_bubble_nop : assert property (
    @(posedge clk) disable iff (rst)
    !id_valid |-> id_instr == NOP_INSTR
  ) else $error("Bubble carries instruction %h", id_instr);

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/1ns

// Fetch front end top joining the fetch stage and the IF/ID register
module fetch_unit import isa_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              stall,                // Hazard hold
  input  logic              update_pc,            // Redirect strobe from decode
  input  logic [ADDR_W-1:0] actual_target,        // Corrected address
  input  logic              wen_bht,
  input  logic              actual_taken,
  input  logic              wen_btb,
  input  logic [ADDR_W-1:0] branch_target,
  output logic              id_valid,
  output logic [ADDR_W-1:0] id_pc,
  output logic [WORD_W-1:0] id_instr,
  output logic [1:0]        id_prediction,
  output logic [ADDR_W-1:0] id_predicted_target
);

  // Fetch outputs into the pipeline register
  logic [ADDR_W-1:0] pc_curr;
  logic [WORD_W-1:0] pc_inst;
  logic [1:0]        prediction;
  logic [ADDR_W-1:0] predicted_target;

  fetch_stage fetch_stage_i (
    .clk              (clk),
    .rst              (rst),
    .stall            (stall),
    .update_pc        (update_pc),
    .actual_target    (actual_target),
    .actual_taken     (actual_taken),
    .wen_bht          (wen_bht),
    .wen_btb          (wen_btb),
    .branch_target    (branch_target),
    .id_pc            (id_pc),          // Fed back for predictor update
    .id_prediction    (id_prediction),
    .pc_curr          (pc_curr),
    .pc_inst          (pc_inst),
    .prediction       (prediction),
    .predicted_target (predicted_target)
  );

  if_id_reg if_id_reg_i (
    .clk                 (clk),
    .rst                 (rst),
    .stall               (stall),
    .update_pc           (update_pc),
    .pc_curr             (pc_curr),
    .pc_inst             (pc_inst),
    .prediction          (prediction),
    .predicted_target    (predicted_target),
    .id_valid            (id_valid),
    .id_pc               (id_pc),
    .id_instr            (id_instr),
    .id_prediction       (id_prediction),
    .id_predicted_target (id_predicted_target)
  );

endmodule

// File: sim/fetch_tb.sv
`timescale 1ns/1ns

// Fetch front end testbench that resolves branches in place of the decode stage
module fetch_tb import isa_pkg::*, bpred_pkg::*; ();

  //////////////////////////////////////////////////////////////////////
  // Run length
  //////////////////////////////////////////////////////////////////////
  localparam int RESET_CYCLES  = 10;
  localparam int START_CYCLES  = 20;    // First fetches after reset
  localparam int SEQ_CYCLES    = 150;   // Straight-line fetch
  localparam int STALL_CYCLES  = 330;   // Random stalls without branch resolution
  localparam int BRANCH_CYCLES = 1500;  // Stalls plus branch resolution
  // All phases plus headroom
  localparam int MAX_CYCLES = RESET_CYCLES + START_CYCLES + SEQ_CYCLES
                            + STALL_CYCLES + BRANCH_CYCLES + 490;

  // Small set of even ROM addresses used as branch targets
  localparam logic [ADDR_W-1:0] TARGETS [8] = '{
    16'h0004, 16'h000C, 16'h0012, 16'h001A, 16'h0020, 16'h002A, 16'h0030, 16'h003C
  };

  // DUT ports
  logic              clk;
  logic              rst;
  logic              stall;
  logic              update_pc;
  logic [ADDR_W-1:0] actual_target;
  logic              wen_bht;
  logic              actual_taken;
  logic              wen_btb;
  logic [ADDR_W-1:0] branch_target;
  logic              id_valid;
  logic [ADDR_W-1:0] id_pc;
  logic [WORD_W-1:0] id_instr;
  logic [1:0]        id_prediction;
  logic [ADDR_W-1:0] id_predicted_target;

  // Reference model
  logic [WORD_W-1:0] rom     [IMEM_WORDS];
  logic [1:0]        m_bht   [BHT_ENTRIES];
  logic [TAG_W-1:0]  m_tag   [BTB_ENTRIES];
  logic [ADDR_W-1:0] m_tgt   [BTB_ENTRIES];
  logic              m_bvld  [BTB_ENTRIES];
  logic [ADDR_W-1:0] m_pc;
  logic              m_valid;   // IF/ID contents from here down
  logic [ADDR_W-1:0] m_id_pc;
  logic [WORD_W-1:0] m_instr;
  logic [1:0]        m_pred;
  logic [ADDR_W-1:0] m_ptgt;
  logic              m_hit;     // BTB tag hit at fetch
  logic              m_tknown;  // BTB entry valid at fetch

  // Bookkeeping
  logic [31:0]       rng;
  int                cycle_cnt;
  int                checks, errors, total_checks, total_errors;
  bit                seq_mode;
  logic [ADDR_W-1:0] seq_pc;
  bit                hold_chk, bubble_chk, redir_pend, tgt_chk;
  logic              hold_valid;
  logic [ADDR_W-1:0] hold_pc, redir_exp, tgt_exp;
  logic [WORD_W-1:0] hold_instr;
  logic [1:0]        hold_pred;

  fetch_unit fetch_unit_i (.*);

  always #5 clk = ~clk;  // 10 ns period

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // One saturating step of a 2-bit counter
  function automatic logic [1:0] ctr_step(input logic [1:0] c, input logic taken);
    if (taken)
      return (c == CTR_ST) ? c : c + 2'd1;
    return (c == CTR_SNT) ? c : c - 2'd1;
  endfunction

  task automatic check(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      $display("ERROR %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("Test %s: %0d checks, %0d errors", name, checks, errors);
    total_checks += checks;
    total_errors += errors;
    checks = 0;
    errors = 0;
  endtask

  task automatic model_reset();
    m_pc     = '0;
    m_valid  = 1'b0;
    m_id_pc  = '0;
    m_instr  = NOP_INSTR;
    m_pred   = CTR_WNT;
    m_ptgt   = '0;
    m_hit    = 1'b0;
    m_tknown = 1'b0;
    for (int i = 0; i < BHT_ENTRIES; i++)
      m_bht[i] = CTR_WNT;  // Weakly not taken after reset
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      m_bvld[i] = 1'b0;
      m_tag[i]  = '0;
      m_tgt[i]  = '0;
    end
  endtask

  // Advance the model by one rising edge with the inputs just driven
  task automatic model_step();
    logic [2:0]        idx;
    logic [2:0]        widx;
    logic [1:0]        pred;
    logic [ADDR_W-1:0] ptgt;
    logic              hit;
    logic              known;
    logic [ADDR_W-1:0] nxt;
    idx   = m_pc[3:1];
    widx  = m_id_pc[3:1];
    pred  = m_bht[idx];      // Lookup sees the tables before this edge's write
    ptgt  = m_tgt[idx];
    known = m_bvld[idx];
    hit   = known && (m_tag[idx] == m_pc[15:4]);
    nxt   = m_pc;
    if (update_pc)
      nxt = actual_target;
    else if (!stall)
      nxt = (pred[1] && hit) ? ptgt : m_pc + 16'd2;
    if (!stall) begin
      if (wen_bht)
        m_bht[widx] = ctr_step(m_pred, actual_taken);
      if (wen_btb) begin
        m_bvld[widx] = 1'b1;
        m_tag[widx]  = m_id_pc[15:4];
        m_tgt[widx]  = branch_target;
      end
    end
    if (update_pc) begin
      m_valid = 1'b0;  // Bubble with the side fields held
      m_instr = NOP_INSTR;
    end else if (!stall) begin
      m_valid  = 1'b1;
      m_id_pc  = m_pc;
      m_instr  = rom[m_pc[5:1]];
      m_pred   = pred;
      m_ptgt   = ptgt;
      m_hit    = hit;
      m_tknown = known;
    end
    m_pc = nxt;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and checks on the falling edge
  //////////////////////////////////////////////////////////////////////
  task automatic drive_inputs(input bit use_stall, input bit resolve);
    logic [31:0] r;
    logic        mispredict;
    r             = next_rand();
    stall         = use_stall && (r[2:0] == 3'd0);  // About one cycle in eight
    update_pc     = 1'b0;
    wen_bht       = 1'b0;
    wen_btb       = 1'b0;
    actual_taken  = 1'b0;
    actual_target = '0;
    branch_target = '0;
    if (resolve && !stall && m_valid && m_instr[OPC_LSB +: OPC_W] == OP_BRANCH) begin
      actual_taken  = (r[9:8] != 2'd0);  // Biased toward taken
      // Mostly a fixed target per branch slot so the BTB gets hits
      branch_target = (r[11:10] == 2'd0) ? TARGETS[r[14:12]] : TARGETS[m_id_pc[3:1]];
      wen_bht       = 1'b1;
      wen_btb       = actual_taken;
      mispredict    = (m_pred[1] != actual_taken)
                   || (actual_taken && !(m_hit && m_ptgt == branch_target));
      update_pc     = mispredict;
      actual_target = actual_taken ? branch_target : m_id_pc + 16'd2;
    end
    // Arm the checks on the next ID contents
    if (update_pc) begin
      bubble_chk = 1'b1;
      redir_pend = 1'b1;
      redir_exp  = actual_target;
    end else if (stall) begin
      hold_chk   = 1'b1;
      hold_valid = m_valid;
      hold_pc    = m_id_pc;
      hold_instr = m_instr;
      hold_pred  = m_pred;
    end else if (m_valid && m_pred[1] && m_hit) begin
      tgt_chk = 1'b1;  // Fetch already went to the BTB target
      tgt_exp = m_ptgt;
    end
  endtask

  task automatic compare_outputs();
    check(id_valid === m_valid, $sformatf("id_valid %b, expected %b", id_valid, m_valid));
    if (!m_valid) begin
      check(id_instr === NOP_INSTR, $sformatf("bubble carries %h", id_instr));
    end else begin
      check(id_pc === m_id_pc, $sformatf("id_pc %h, expected %h", id_pc, m_id_pc));
      check(id_instr === m_instr, $sformatf("id_instr %h, expected %h", id_instr, m_instr));
      check(id_prediction === m_pred,
            $sformatf("counter %0d at %h, expected %0d", id_prediction, id_pc, m_pred));
      if (m_tknown)
        check(id_predicted_target === m_ptgt,
              $sformatf("predicted target %h, expected %h", id_predicted_target, m_ptgt));
    end
    if (seq_mode) begin
      check(id_valid === 1'b1 && id_pc === seq_pc,
            $sformatf("sequential id_pc %h, expected %h", id_pc, seq_pc));
      check(id_instr === rom[seq_pc[5:1]], $sformatf("ROM word %h at %h", id_instr, seq_pc));
      seq_pc = seq_pc + 16'd2;
    end
    if (hold_chk)
      check(id_valid === hold_valid && (!hold_valid || (id_pc === hold_pc
            && id_instr === hold_instr && id_prediction === hold_pred)),
            $sformatf("ID moved under stall, id_pc %h, expected %h", id_pc, hold_pc));
    if (bubble_chk)
      check(id_valid === 1'b0 && id_instr === NOP_INSTR,
            $sformatf("no bubble after redirect, id_instr %h", id_instr));
    if (redir_pend && m_valid) begin
      check(id_pc === redir_exp, $sformatf("redirect to %h, expected %h", id_pc, redir_exp));
      redir_pend = 1'b0;
    end
    if (tgt_chk)
      check(id_valid === 1'b1 && id_pc === tgt_exp,
            $sformatf("BTB fetch at %h, expected %h", id_pc, tgt_exp));
    hold_chk   = 1'b0;
    bubble_chk = 1'b0;
    tgt_chk    = 1'b0;
  endtask

  task automatic run_cycles(input int n, input bit use_stall, input bit resolve);
    repeat (n) begin
      compare_outputs();  // Result of the last rising edge
      drive_inputs(use_stall, resolve);
      model_step();
      @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin : main
    clk           = 1'b0;
    rst           = 1'b1;
    stall         = 1'b0;
    update_pc     = 1'b0;
    actual_target = '0;
    wen_bht       = 1'b0;
    actual_taken  = 1'b0;
    wen_btb       = 1'b0;
    branch_target = '0;
    rng           = 32'd52490;
    {checks, errors, total_checks, total_errors} = '0;
    {seq_mode, hold_chk, bubble_chk, redir_pend, tgt_chk} = '0;
    $readmemh("sim/imem.hex", rom);
    model_reset();
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;

    check(id_valid === 1'b0, "id_valid high right after reset");
    run_cycles(1, 1'b0, 1'b0);
    check(id_valid === 1'b1 && id_pc === 16'h0000 && id_prediction === CTR_WNT,
          $sformatf("first fetch at %h with counter %0d", id_pc, id_prediction));
    run_cycles(START_CYCLES - 1, 1'b0, 1'b0);
    report_test("reset");

    seq_mode = 1'b1;
    seq_pc   = m_id_pc;
    run_cycles(SEQ_CYCLES, 1'b0, 1'b0);
    seq_mode = 1'b0;
    report_test("sequential");

    run_cycles(STALL_CYCLES, 1'b1, 1'b0);
    report_test("stall");

    run_cycles(BRANCH_CYCLES, 1'b1, 1'b1);
    compare_outputs();
    report_test("branch");

    $display("Total: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // Watchdog on rising edges
  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run still going after %0d cycles", MAX_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: sim/imem.hex
// One 16-bit instruction word per line in hex, word 0 first
// Opcode C in bits 15 to 12 marks a conditional branch, 0000 is never used
1101
2212
C006
3323
4434
C00A
5545
1156
6656
C012
7767
2278
8878
C01E
9989
3390
A09A
C024
B0AB
44BC
D0BC
C008
E0CD
55DE
F0DE
C030
1EF0
6601
2F01
C03A
7712
3A23

// File: compile.f
design/isa_pkg.sv
design/bpred_pkg.sv
design/branch_predictor.sv
design/fetch_stage.sv
design/if_id_reg.sv
design/fetch_unit.sv
sim/fetch_tb.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench
# Any variable can be set on the command line, for example make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILE_LIST ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
HEX_SRC   ?= sim/imem.hex
HEX_RUN   ?= imem.hex
VFLAGS    ?= --binary --assert --timescale 1ns/1ns -j 0
FAIL_MSG  ?= Simulation failed

SRCS    := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and scan $(LOG)"
	@echo "  clean  remove $(OBJ_DIR), $(LOG) and the ROM image copy"
	@echo "  help   show this list"

$(SIM_BIN): $(FILE_LIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# The ROM opens its image from the run directory
test: $(SIM_BIN)
	cp $(HEX_SRC) $(HEX_RUN)
	$(abspath $(SIM_BIN)) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; else echo "PASS"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG) $(HEX_RUN)
